// File: logic/icache_pkg.sv
package icache_pkg;

    // Fetch and backing memory byte address
    typedef logic [31:0] addr_t;

    // One instruction word as seen on the fetch port
    typedef logic [31:0] insn_t;

    // Default geometry, 2 ways of 16 sets
    localparam int DEF_WAYS = 2;

    // log2 of the number of sets
    localparam int DEF_SET_WIDTH = 4;

    // log2 of the line size in bytes, 16 bytes or 4 words
    localparam int DEF_BLOCK_WIDTH = 4;

endpackage

// File: logic/spr_pkg.sv
package spr_pkg;

    // SPR number on the special purpose register bus
    typedef logic [15:0] spr_addr_t;

    // SPR write data
    typedef logic [31:0] spr_data_t;

    // Instruction cache block invalidate register
    localparam spr_addr_t SPR_ICBIR = 16'h2002;

endpackage

// File: logic/dpram_sclk.sv
module dpram_sclk #(
    parameter int ADDR_WIDTH = 4,
    parameter int DATA_WIDTH = 32
) (
    input  logic                  clk,
    input  logic [ADDR_WIDTH-1:0] raddr_i,
    input  logic [ADDR_WIDTH-1:0] waddr_i,
    input  logic                  we_i,
    input  logic [DATA_WIDTH-1:0] din_i,
    output logic [DATA_WIDTH-1:0] dout_o
);

    // One entry per address
    logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];

    // Write port
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_i] <= din_i;
        end
    end

    // Registered read, no bypass
    // A read colliding with a write returns the old entry
    always_ff @(posedge clk) begin
        dout_o <= mem[raddr_i];
    end

    // Write address must come from a settled index
    wr_adr_known: assert property (@(posedge clk) we_i |-> !$isunknown(waddr_i))
        else $error("dpram_sclk: write with unknown address");

endmodule

// File: logic/cache_lru.sv
module cache_lru #(
    parameter int NUM_WAYS = 2
) (
    input  logic [NUM_WAYS*(NUM_WAYS-1)/2-1:0] current_i,
    input  logic [NUM_WAYS-1:0]                access_i,
    output logic [NUM_WAYS*(NUM_WAYS-1)/2-1:0] update_o,
    output logic [NUM_WAYS-1:0]                lru_pre_o
);

    // One history bit per pair of ways i < j
    // Bit set means way i was used before way j
    logic [NUM_WAYS-1:0][NUM_WAYS-1:0] older;

    always_comb begin
        int unsigned k;
        k = 0;
        older = '0;
        update_o = current_i;
        for (int i = 0; i < NUM_WAYS; i++) begin
            // Diagonal set so a way never blocks itself
            older[i][i] = 1'b1;
            for (int j = i + 1; j < NUM_WAYS; j++) begin
                older[i][j] = current_i[k];
                older[j][i] = !current_i[k];
                // Accessed way becomes the newer one of the pair
                if (access_i[i]) begin
                    update_o[k] = 1'b0;
                end
                if (access_i[j]) begin
                    update_o[k] = 1'b1;
                end
                k++;
            end
        end
    end

    // LRU way is older than every other way
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            lru_pre_o[w] = &older[w];
        end
    end

    // Controller may touch at most one way per update
    always_comb begin
        access_onehot: assert ($onehot0(access_i))
            else $error("cache_lru: access vector not one-hot");
    end

endmodule

// File: logic/icache_ctrl.sv
module icache_ctrl #(
    parameter int WAYS        = 2,
    parameter int SET_WIDTH   = 4,
    parameter int BLOCK_WIDTH = 4
) (
    input  logic                         clk,
    input  logic                         rst,

    input  logic                         cpu_req_i,
    input  icache_pkg::addr_t            cpu_adr_i,
    output logic                         cpu_ack_o,
    output icache_pkg::insn_t            cpu_dat_o,

    input  logic                         spr_stb_i,
    input  logic                         spr_we_i,
    input  spr_pkg::spr_addr_t           spr_addr_i,
    input  spr_pkg::spr_data_t           spr_dat_i,
    output logic                         spr_ack_o,

    output logic                         refill_req_o,
    output icache_pkg::addr_t            refill_adr_o,
    input  logic                         line_we_i,
    input  logic [(8<<BLOCK_WIDTH)-1:0]  line_dat_i,

    output logic                         refill_o
);

    import icache_pkg::*;
    import spr_pkg::*;

    localparam int ADR_WIDTH    = $bits(addr_t);
    localparam int INSN_WIDTH   = $bits(insn_t);
    localparam int LINE_WIDTH   = 8 << BLOCK_WIDTH;
    localparam int WAY_WIDTH    = BLOCK_WIDTH + SET_WIDTH;
    localparam int TAG_WIDTH    = ADR_WIDTH - WAY_WIDTH;
    // Per way: valid bit above the tag
    localparam int ENTRY_WIDTH  = TAG_WIDTH + 1;
    localparam int LRU_WIDTH    = WAYS * (WAYS - 1) / 2;
    // Keep a one bit history field for a direct mapped cache
    localparam int LRU_BITS     = (WAYS >= 2) ? LRU_WIDTH : 1;
    // Tag entry is {lru, way N-1, ..., way 0}
    localparam int TAGMEM_WIDTH = WAYS * ENTRY_WIDTH + LRU_BITS;

    typedef logic [SET_WIDTH-1:0] set_t;
    typedef logic [TAG_WIDTH-1:0] tag_t;
    typedef enum logic [1:0] {IDLE, READ, REFILL, INVALIDATE} state_t;

    state_t state;

    // High in the cycle after an ack, RAM outputs belong to the old address
    logic stale_q;
    logic lookup;
    logic hit;
    logic miss;

    logic spr_accept;
    logic icbir_wr;
    set_t inv_set;

    set_t cpu_set;
    tag_t cpu_tag;
    set_t tag_windex;
    logic [BLOCK_WIDTH-3:0] word_sel;

    logic [TAGMEM_WIDTH-1:0] tag_dout;
    logic [TAGMEM_WIDTH-1:0] tag_din;
    logic tag_we;
    logic [WAYS-1:0][ENTRY_WIDTH-1:0] ways_out;
    logic [WAYS-1:0][ENTRY_WIDTH-1:0] ways_in;
    logic [WAYS-1:0][ENTRY_WIDTH-1:0] ways_save;
    logic [LRU_BITS-1:0] lru_out;
    logic [LRU_BITS-1:0] lru_in;
    logic [LRU_BITS-1:0] lru_next;

    logic [WAYS-1:0] way_hit;
    logic [WAYS-1:0] way_we;
    logic [WAYS-1:0] lru_pre;
    logic [WAYS-1:0] victim_q;
    logic [WAYS-1:0] access;
    logic [LINE_WIDTH-1:0] way_dout [WAYS];

    // Address split
    assign cpu_set  = cpu_adr_i[WAY_WIDTH-1:BLOCK_WIDTH];
    assign cpu_tag  = cpu_adr_i[ADR_WIDTH-1:WAY_WIDTH];
    assign word_sel = cpu_adr_i[BLOCK_WIDTH-1:2];

    assign {lru_out, ways_out} = tag_dout;
    assign tag_din = {lru_in, ways_in};

    // Tag compare per way
    for (genvar i = 0; i < WAYS; i++) begin : gen_cmp
        assign way_hit[i] = ways_out[i][TAG_WIDTH] && (ways_out[i][TAG_WIDTH-1:0] == cpu_tag);
    end

    // Compare only when the RAM outputs match the held address
    assign lookup    = (state == READ) && cpu_req_i && !stale_q;
    assign hit       = |way_hit;
    assign miss      = lookup && !hit;
    assign cpu_ack_o = lookup && hit;

    // Word of the hitting way
    always_comb begin
        cpu_dat_o = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (way_hit[w]) begin
                cpu_dat_o = way_dout[w][INSN_WIDTH*word_sel +: INSN_WIDTH];
            end
        end
    end

    // Refill runs on the line of the held fetch address
    assign refill_o     = (state == REFILL);
    assign refill_req_o = (state == REFILL);
    assign refill_adr_o = {cpu_adr_i[ADR_WIDTH-1:BLOCK_WIDTH], {BLOCK_WIDTH{1'b0}}};

    // SPR strobes wait while a line is in flight
    assign icbir_wr   = spr_we_i && (spr_addr_i == SPR_ICBIR);
    assign spr_accept = spr_stb_i && !spr_ack_o && (state == IDLE || state == READ);

    always_ff @(posedge clk) begin
        spr_ack_o <= 1'b0;
        stale_q   <= cpu_ack_o;
        case (state)
            IDLE: begin
                if (cpu_req_i) begin
                    state <= READ;
                end
            end
            READ: begin
                if (!cpu_req_i) begin
                    state <= IDLE;
                end else if (miss) begin
                    // Victim and old entries for the line write
                    victim_q  <= lru_pre;
                    ways_save <= ways_out;
                    state     <= REFILL;
                end
            end
            REFILL: begin
                if (line_we_i) begin
                    state <= IDLE;
                end
            end
            INVALIDATE: begin
                spr_ack_o <= 1'b1;
                state     <= IDLE;
            end
            default: begin
                state <= IDLE;
            end
        endcase

        // Invalidate overrides a lookup in progress, the fetch retries after
        if (spr_accept) begin
            if (icbir_wr) begin
                inv_set <= spr_dat_i[WAY_WIDTH-1:BLOCK_WIDTH];
                state   <= INVALIDATE;
            end else begin
                spr_ack_o <= 1'b1;
            end
        end

        if (rst) begin
            state     <= IDLE;
            stale_q   <= 1'b0;
            spr_ack_o <= 1'b0;
        end
    end

    // Tag and data write control
    always_comb begin
        ways_in = ways_out;
        lru_in  = lru_out;
        tag_we  = 1'b0;
        way_we  = '0;
        access  = '0;
        case (state)
            READ: begin
                // Hit only refreshes the history
                if (cpu_ack_o) begin
                    access = way_hit;
                    lru_in = lru_next;
                    tag_we = 1'b1;
                end
            end
            REFILL: begin
                if (line_we_i) begin
                    way_we = victim_q;
                    access = victim_q;
                    for (int w = 0; w < WAYS; w++) begin
                        ways_in[w] = victim_q[w] ? {1'b1, cpu_tag} : ways_save[w];
                    end
                    lru_in = lru_next;
                    tag_we = 1'b1;
                end
            end
            INVALIDATE: begin
                // Whole set cleared, history too
                ways_in = '0;
                lru_in  = '0;
                tag_we  = 1'b1;
            end
            default: begin
            end
        endcase
    end

    assign tag_windex = (state == INVALIDATE) ? inv_set : cpu_set;

    dpram_sclk #(
        .ADDR_WIDTH (SET_WIDTH),
        .DATA_WIDTH (TAGMEM_WIDTH)
    ) u_tag_ram (
        .clk     (clk),
        .raddr_i (cpu_set),
        .waddr_i (tag_windex),
        .we_i    (tag_we),
        .din_i   (tag_din),
        .dout_o  (tag_dout)
    );

    for (genvar i = 0; i < WAYS; i++) begin : gen_way
        dpram_sclk #(
            .ADDR_WIDTH (SET_WIDTH),
            .DATA_WIDTH (LINE_WIDTH)
        ) u_data_ram (
            .clk     (clk),
            .raddr_i (cpu_set),
            .waddr_i (cpu_set),
            .we_i    (way_we[i]),
            .din_i   (line_dat_i),
            .dout_o  (way_dout[i])
        );
    end

    if (WAYS >= 2) begin : gen_lru
        cache_lru #(
            .NUM_WAYS (WAYS)
        ) u_lru (
            .current_i (lru_out),
            .access_i  (access),
            .update_o  (lru_next),
            .lru_pre_o (lru_pre)
        );
    end else begin : gen_no_lru
        // Single way is always the victim
        assign lru_pre  = 1'b1;
        assign lru_next = lru_out;
    end

    // Ack only from a lookup whose address was already there at the RAM read
    ack_in_read: assert property (@(posedge clk) disable iff (rst)
        cpu_ack_o |-> state == READ && $stable(cpu_adr_i))
        else $error("icache_ctrl: ack outside READ or on a changed address");

    // Refill writes the tag to the victim only, so no duplicate lines
    one_way_hit: assert property (@(posedge clk) disable iff (rst)
        lookup |-> $onehot0(way_hit))
        else $error("icache_ctrl: more than one way hit");

endmodule

// File: logic/icache_refill.sv
module icache_refill #(
    parameter int BLOCK_WIDTH = 4
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         refill_req_i,
    input  icache_pkg::addr_t            refill_adr_i,
    output logic                         mem_req_o,
    output icache_pkg::addr_t            mem_adr_o,
    input  logic                         mem_ack_i,
    input  icache_pkg::insn_t            mem_dat_i,
    output logic                         line_we_o,
    output logic [(8<<BLOCK_WIDTH)-1:0]  line_dat_o
);

    import icache_pkg::*;

    localparam int LINE_WIDTH = 8 << BLOCK_WIDTH;
    localparam int INSN_WIDTH = $bits(insn_t);
    localparam int CNT_WIDTH  = BLOCK_WIDTH - 2;
    // Byte offset bits inside a line
    localparam addr_t OFFSET_MASK = addr_t'((1 << BLOCK_WIDTH) - 1);

    typedef logic [CNT_WIDTH-1:0] word_cnt_t;
    // GAP drops the request for a cycle between words
    typedef enum logic [1:0] {IDLE, REQ, GAP, DONE} state_t;

    state_t    state;
    word_cnt_t word_cnt;
    addr_t     line_adr;

    assign mem_req_o = (state == REQ);
    assign mem_adr_o = line_adr | addr_t'({word_cnt, 2'b00});
    assign line_we_o = (state == DONE);

    always_ff @(posedge clk) begin
        case (state)
            IDLE: begin
                if (refill_req_i) begin
                    line_adr <= refill_adr_i & ~OFFSET_MASK;
                    word_cnt <= '0;
                    state    <= REQ;
                end
            end
            REQ: begin
                if (mem_ack_i) begin
                    // Words arrive from offset 0, so shift down
                    line_dat_o <= {mem_dat_i, line_dat_o[LINE_WIDTH-1:INSN_WIDTH]};
                    if (&word_cnt) begin
                        state <= DONE;
                    end else begin
                        word_cnt <= word_cnt + 1'b1;
                        state    <= GAP;
                    end
                end
            end
            GAP: begin
                state <= REQ;
            end
            DONE: begin
                // One cycle line write pulse
                state <= IDLE;
            end
            default: begin
                state <= IDLE;
            end
        endcase

        if (rst) begin
            state    <= IDLE;
            word_cnt <= '0;
        end
    end

    // Memory answers only an open request
    ack_in_req: assert property (@(posedge clk) disable iff (rst) mem_ack_i |-> mem_req_o)
        else $error("icache_refill: memory ack without request");

endmodule

// File: logic/icache_top.sv
module icache_top #(
    parameter int WAYS        = icache_pkg::DEF_WAYS,
    parameter int SET_WIDTH   = icache_pkg::DEF_SET_WIDTH,
    parameter int BLOCK_WIDTH = icache_pkg::DEF_BLOCK_WIDTH
) (
    input  logic               clk,
    input  logic               rst,

    // Fetch port
    input  logic               cpu_req_i,
    input  icache_pkg::addr_t  cpu_adr_i,
    output logic               cpu_ack_o,
    output icache_pkg::insn_t  cpu_dat_o,

    // SPR port, writes only
    input  logic               spr_stb_i,
    input  logic               spr_we_i,
    input  spr_pkg::spr_addr_t spr_addr_i,
    input  spr_pkg::spr_data_t spr_dat_i,
    output logic               spr_ack_o,

    // Backing memory, one word read at a time
    output logic               mem_req_o,
    output icache_pkg::addr_t  mem_adr_o,
    input  logic               mem_ack_i,
    input  icache_pkg::insn_t  mem_dat_i,

    output logic               refill_o
);

    localparam int LINE_WIDTH = 8 << BLOCK_WIDTH;

    // Controller to sequencer
    logic                  refill_req;
    icache_pkg::addr_t     refill_adr;
    logic                  line_we;
    logic [LINE_WIDTH-1:0] line_dat;

    icache_ctrl #(
        .WAYS        (WAYS),
        .SET_WIDTH   (SET_WIDTH),
        .BLOCK_WIDTH (BLOCK_WIDTH)
    ) u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .cpu_req_i    (cpu_req_i),
        .cpu_adr_i    (cpu_adr_i),
        .cpu_ack_o    (cpu_ack_o),
        .cpu_dat_o    (cpu_dat_o),
        .spr_stb_i    (spr_stb_i),
        .spr_we_i     (spr_we_i),
        .spr_addr_i   (spr_addr_i),
        .spr_dat_i    (spr_dat_i),
        .spr_ack_o    (spr_ack_o),
        .refill_req_o (refill_req),
        .refill_adr_o (refill_adr),
        .line_we_i    (line_we),
        .line_dat_i   (line_dat),
        .refill_o     (refill_o)
    );

    icache_refill #(
        .BLOCK_WIDTH (BLOCK_WIDTH)
    ) u_refill (
        .clk          (clk),
        .rst          (rst),
        .refill_req_i (refill_req),
        .refill_adr_i (refill_adr),
        .mem_req_o    (mem_req_o),
        .mem_adr_o    (mem_adr_o),
        .mem_ack_i    (mem_ack_i),
        .mem_dat_i    (mem_dat_i),
        .line_we_o    (line_we),
        .line_dat_o   (line_dat)
    );

endmodule

// File: dv/tb_icache.sv
module tb_icache;

    import icache_pkg::*;
    import spr_pkg::*;

    localparam int WAYS       = DEF_WAYS;
    localparam int SET_W      = DEF_SET_WIDTH;
    localparam int BLOCK_W    = DEF_BLOCK_WIDTH;
    localparam int SETS       = 1 << SET_W;
    localparam int LINE_WORDS = 1 << (BLOCK_W - 2);
    localparam addr_t LINE_MASK = ~addr_t'((1 << BLOCK_W) - 1);
    // A miss takes at most LINE_WORDS reads of up to 6 cycles each
    localparam int FETCH_TIMEOUT = 200;
    localparam int SPR_TIMEOUT   = 20;

    logic       clk = 1'b0;
    logic       rst;
    logic       cpu_req_i;
    addr_t      cpu_adr_i;
    logic       cpu_ack_o;
    insn_t      cpu_dat_o;
    logic       spr_stb_i;
    logic       spr_we_i;
    spr_addr_t  spr_addr_i;
    spr_data_t  spr_dat_i;
    logic       spr_ack_o;
    logic       mem_req_o;
    addr_t      mem_adr_o;
    logic       mem_ack_i = 1'b0;
    insn_t      mem_dat_i = '0;
    logic       refill_o;

    // Backing memory and monitor state
    logic [31:0] mem_rng = 32'd7042;
    logic [31:0] stim_rng = 32'd7042;
    bit    mem_busy;
    int    mem_wait;
    logic  req_prev;
    logic  refill_prev;
    int    req_rises;
    int    refill_rises;
    addr_t read_log [$];

    // Reference model, one entry per set and way
    addr_t m_tag   [SETS][WAYS];
    bit    m_valid [SETS][WAYS];
    int    m_stamp [SETS][WAYS];
    int    stamp_ctr;
    int    model_misses;

    // Expected hits for A, B, A, C, A, B in one set
    bit lru_expect [6] = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0};

    icache_top dut (
        .clk        (clk),
        .rst        (rst),
        .cpu_req_i  (cpu_req_i),
        .cpu_adr_i  (cpu_adr_i),
        .cpu_ack_o  (cpu_ack_o),
        .cpu_dat_o  (cpu_dat_o),
        .spr_stb_i  (spr_stb_i),
        .spr_we_i   (spr_we_i),
        .spr_addr_i (spr_addr_i),
        .spr_dat_i  (spr_dat_i),
        .spr_ack_o  (spr_ack_o),
        .mem_req_o  (mem_req_o),
        .mem_adr_o  (mem_adr_o),
        .mem_ack_i  (mem_ack_i),
        .mem_dat_i  (mem_dat_i),
        .refill_o   (refill_o)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] next_stim();
        stim_rng = lcg_step(stim_rng);
        return stim_rng >> 8;
    endfunction

    // Memory contents are a fixed function of the word address
    function automatic insn_t mem_word(input addr_t adr);
        return adr ^ 32'h5EED_C0DE;
    endfunction

    function automatic int set_of(input addr_t adr);
        return int'(adr[SET_W+BLOCK_W-1:BLOCK_W]);
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("MISMATCH %s expected %08h actual %08h", name, exp, act);
            abort_run("value check failed");
        end
    endtask

    // Memory answers each request after 1 to 5 cycles, one word at a time
    always @(negedge clk) begin
        if (!rst) begin
            if (mem_req_o && !req_prev) begin
                req_rises++;
            end
            if (refill_o && !refill_prev) begin
                refill_rises++;
            end
            req_prev = mem_req_o;
            refill_prev = refill_o;
            mem_ack_i <= 1'b0;
            if (mem_req_o && !mem_ack_i) begin
                if (!mem_busy) begin
                    mem_rng = lcg_step(mem_rng);
                    mem_wait = int'((mem_rng >> 16) % 5);
                    mem_busy = 1'b1;
                end
                if (mem_wait == 0) begin
                    mem_ack_i <= 1'b1;
                    mem_dat_i <= mem_word(mem_adr_o);
                    read_log.push_back(mem_adr_o);
                    mem_busy = 1'b0;
                end else begin
                    mem_wait--;
                end
            end
        end
    end

    task automatic model_invalidate(input int s);
        for (int w = 0; w < WAYS; w++) begin
            m_valid[s][w] = 1'b0;
            m_stamp[s][w] = 0;
        end
    endtask

    // Predict hit or miss and update tags and LRU order
    task automatic predict_access(input addr_t adr, output bit hit);
        int s;
        int victim;
        addr_t tag;
        s = set_of(adr);
        tag = adr >> (SET_W + BLOCK_W);
        stamp_ctr++;
        hit = 1'b0;
        victim = -1;
        for (int w = 0; w < WAYS; w++) begin
            if (m_valid[s][w] && m_tag[s][w] == tag) begin
                hit = 1'b1;
                m_stamp[s][w] = stamp_ctr;
            end
        end
        if (!hit) begin
            model_misses++;
            // Empty way first, else the oldest one
            for (int w = 0; w < WAYS; w++) begin
                if (!m_valid[s][w] && victim < 0) begin
                    victim = w;
                end
            end
            if (victim < 0) begin
                victim = 0;
                for (int w = 1; w < WAYS; w++) begin
                    if (m_stamp[s][w] < m_stamp[s][victim]) begin
                        victim = w;
                    end
                end
            end
            m_valid[s][victim] = 1'b1;
            m_tag[s][victim] = tag;
            m_stamp[s][victim] = stamp_ctr;
        end
    endtask

    // One fetch, called on a falling edge, returns on a falling edge
    task automatic fetch(input addr_t adr, input string name, output bit was_hit);
        bit exp_hit;
        bit saw_refill;
        int cycles;
        int rises0;
        insn_t got;
        addr_t base;
        predict_access(adr, exp_hit);
        read_log.delete();
        rises0 = req_rises;
        base = adr & LINE_MASK;
        cpu_adr_i = adr;
        cpu_req_i = 1'b1;
        cycles = 0;
        saw_refill = 1'b0;
        do begin
            @(negedge clk);
            cycles++;
            if (refill_o) begin
                saw_refill = 1'b1;
            end
            if (cycles > FETCH_TIMEOUT) begin
                abort_run({"timeout waiting for cpu_ack_o in ", name});
            end
        end while (!cpu_ack_o);
        got = cpu_dat_o;
        // Address held through the ack cycle
        @(negedge clk);
        cpu_req_i = 1'b0;
        check_val({name, " data"}, mem_word(adr), got);
        check_val({name, " hit"}, 32'(exp_hit), 32'(!saw_refill));
        check_val({name, " mem reads"}, exp_hit ? 32'd0 : 32'(LINE_WORDS), 32'(read_log.size()));
        check_val({name, " req rises"}, exp_hit ? 32'd0 : 32'(LINE_WORDS),
                  32'(req_rises - rises0));
        for (int i = 0; i < read_log.size(); i++) begin
            check_val({name, " read adr"}, base + addr_t'(i * 4), read_log[i]);
        end
        if (exp_hit) begin
            check_val({name, " hit latency"}, 32'd1, 32'(cycles));
        end
        was_hit = !saw_refill;
    endtask

    task automatic spr_write(input spr_addr_t num, input spr_data_t val);
        int cycles;
        spr_stb_i = 1'b1;
        spr_we_i = 1'b1;
        spr_addr_i = num;
        spr_dat_i = val;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > SPR_TIMEOUT) begin
                abort_run("timeout waiting for spr_ack_o");
            end
        end while (!spr_ack_o);
        // Strobe held through the ack cycle
        @(negedge clk);
        spr_stb_i = 1'b0;
        spr_we_i = 1'b0;
        if (num == SPR_ICBIR) begin
            check_val("icbir ack latency", 32'd2, 32'(cycles));
            model_invalidate(set_of(val));
        end
    endtask

    initial begin
        logic [31:0] r;
        bit h;
        int misses0;
        int refills0;
        rst = 1'b1;
        cpu_req_i = 1'b0;
        cpu_adr_i = '0;
        spr_stb_i = 1'b0;
        spr_we_i = 1'b0;
        spr_addr_i = '0;
        spr_dat_i = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Tag RAM is unknown after reset
        for (int s = 0; s < SETS; s++) begin
            spr_write(SPR_ICBIR, spr_data_t'(s << BLOCK_W));
        end

        // Small window, one line per set
        repeat (40) begin
            r = next_stim();
            fetch(addr_t'(32'h0000_1000 + ((r & 32'h3F) << 2)), "window", h);
        end

        // A, B and C share set 5, B gets evicted
        spr_write(SPR_ICBIR, 32'h0000_0050);
        fetch(32'h0001_0050, "lru A", h);
        check_val("lru step 0", 32'(lru_expect[0]), 32'(h));
        fetch(32'h0002_0054, "lru B", h);
        check_val("lru step 1", 32'(lru_expect[1]), 32'(h));
        fetch(32'h0001_0058, "lru A", h);
        check_val("lru step 2", 32'(lru_expect[2]), 32'(h));
        fetch(32'h0003_005C, "lru C", h);
        check_val("lru step 3", 32'(lru_expect[3]), 32'(h));
        fetch(32'h0001_0050, "lru A", h);
        check_val("lru step 4", 32'(lru_expect[4]), 32'(h));
        fetch(32'h0002_0050, "lru B", h);
        check_val("lru step 5", 32'(lru_expect[5]), 32'(h));

        // Two lines in set 3, one in set 9
        fetch(32'h0002_0030, "inv P", h);
        fetch(32'h0004_0034, "inv Q", h);
        fetch(32'h0002_0098, "inv R", h);
        // Other SPR number changes nothing
        spr_write(16'h2001, 32'h0000_0030);
        fetch(32'h0002_0030, "other spr P", h);
        check_val("other spr P hit", 32'd1, 32'(h));
        fetch(32'h0004_0034, "other spr Q", h);
        check_val("other spr Q hit", 32'd1, 32'(h));
        spr_write(SPR_ICBIR, 32'h0000_0030);
        fetch(32'h0002_0030, "icbir P", h);
        check_val("icbir P hit", 32'd0, 32'(h));
        fetch(32'h0004_0034, "icbir Q", h);
        check_val("icbir Q hit", 32'd0, 32'(h));
        fetch(32'h0002_0098, "icbir R", h);
        check_val("icbir R hit", 32'd1, 32'(h));

        // Long mix, 4 lines per set compete for 2 ways
        misses0 = model_misses;
        refills0 = refill_rises;
        repeat (200) begin
            r = next_stim();
            if (r[2:0] == 3'd0) begin
                spr_write(SPR_ICBIR, spr_data_t'(r << 1));
            end else begin
                fetch(addr_t'(32'h0000_8000 + (((r >> 3) & 32'hFF) << 2)), "mix", h);
            end
            if (r[20]) begin
                @(negedge clk);
            end
        end
        check_val("mix miss count", 32'(model_misses - misses0), 32'(refill_rises - refills0));

        $display("test passed");
        $finish;
    end

endmodule

// File: tb.f
logic/icache_pkg.sv
logic/spr_pkg.sv
logic/dpram_sclk.sv
logic/cache_lru.sv
logic/icache_ctrl.sv
logic/icache_refill.sv
logic/icache_top.sv
dv/tb_icache.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_icache -o tb_icache

# Simulation status is taken from the log
./obj_dir/tb_icache > sim.log 2>&1 || true
cat sim.log

if grep -qx "test passed" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
